// ==== rtl/mmc_pkg.sv ====
//
// MMC link engine shared types
// Lane control and status records, width types, and the
// bit-serial CRC-7 and CRC-16 (CCITT) step functions
//
package mmc_pkg;

    typedef logic [7:0]  mmc_byte_t;
    typedef logic [7:0]  mmc_div_t;
    typedef logic [6:0]  mmc_crc7_t;
    typedef logic [15:0] mmc_crc16_t;
    typedef logic [31:0] mmc_timer_t;

    // Sampled only with start_communication
    typedef struct packed {
        logic       receive;
        logic       check_start;
        logic       clear_crc;
        logic       clear_irq;
        logic       load;
        mmc_byte_t  tx_byte;
    } mmc_lane_ctrl_t;

    typedef struct packed {
        mmc_byte_t  rx_byte;
        logic       tx_done;
        logic       rx_done;
    } mmc_lane_stat_t;

    // x^7 + x^3 + 1, MSB first
    function automatic mmc_crc7_t crc7_step(input mmc_crc7_t crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

    // x^16 + x^12 + x^5 + 1, MSB first
    function automatic mmc_crc16_t crc16_step(input mmc_crc16_t crc, input logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    endfunction

endpackage

// ==== rtl/mmc_clock_gen.sv ====
//
// MMC clock generator
// Divides the system clock into mmc_clk and flags the cycles
// on which mmc_clk rises (sample) and falls (shift)
//
module mmc_clock_gen import mmc_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     run,
    input  mmc_div_t mmc_clock_cycle,
    output logic     mmc_clk,
    output logic     sample_edge,
    output logic     shift_edge
);

    mmc_div_t half_period;
    mmc_div_t cycle_count;
    logic     edge_hit;

    // Half period never below one clock
    assign half_period = (mmc_clock_cycle[7:1] == 7'd0) ? 8'd1 : {1'b0, mmc_clock_cycle[7:1]};
    assign edge_hit    = run & (cycle_count >= half_period);

    always_ff @(posedge clock) begin
        if (reset || !run)
            cycle_count <= 8'd1;
        else if (edge_hit)
            cycle_count <= 8'd1;
        else
            cycle_count <= cycle_count + 8'd1;
    end

    always_ff @(posedge clock) begin
        if (reset || !run)
            mmc_clk <= 1'b0;
        else if (edge_hit)
            mmc_clk <= ~mmc_clk;
    end

    assign sample_edge = edge_hit & ~mmc_clk;
    assign shift_edge  = edge_hit & mmc_clk;

endmodule

// ==== rtl/mmc_lane.sv ====
//
// MMC serial lane
// Moves one byte per transaction on a single pin in either
// direction, with optional start-bit hunt on receive and a
// running CRC whose polynomial follows crc_width (7 or 16)
//
module mmc_lane import mmc_pkg::*; #(
    parameter int crc_width = 7
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start_communication,
    input  mmc_lane_ctrl_t       ctrl,
    input  logic                 sample_edge,
    input  logic                 shift_edge,
    input  logic                 pin_in,
    output mmc_lane_stat_t       stat,
    output logic [crc_width-1:0] crc,
    output logic                 pin_out,
    output logic                 pin_io
);

    mmc_byte_t            tx_register;
    mmc_byte_t            rx_register;
    logic                 start_seen;
    logic [3:0]           bit_count;
    logic                 tx_done;
    logic                 rx_done;
    logic                 count_bit;
    logic                 crc_bit;
    logic [crc_width-1:0] crc_next;

    // A bit counts once the start bit is seen, or it is the start bit itself
    assign count_bit = sample_edge & (bit_count != 4'd8) &
                       (~pin_io | start_seen | ~pin_in);
    assign crc_bit   = pin_io ? pin_in : tx_register[7];

    // Pin direction
    always_ff @(posedge clock) begin
        if (reset)
            pin_io <= 1'b1;
        else if (start_communication)
            pin_io <= ctrl.receive;
    end

    // Start-bit detector
    always_ff @(posedge clock) begin
        if (reset)
            start_seen <= 1'b0;
        else if (start_communication)
            start_seen <= ~(ctrl.receive & ctrl.check_start);
        else if (count_bit && pin_io)
            start_seen <= 1'b1;
    end

    // Bit count, stops at 8
    always_ff @(posedge clock) begin
        if (reset)
            bit_count <= 4'd0;
        else if (start_communication)
            bit_count <= 4'd0;
        else if (count_bit)
            bit_count <= bit_count + 4'd1;
    end

    // Transmit register, refilled with ones behind the data
    always_ff @(posedge clock) begin
        if (start_communication && ctrl.load)
            tx_register <= ctrl.tx_byte;
        else if (shift_edge)
            tx_register <= {tx_register[6:0], 1'b1};
    end

    assign pin_out = pin_io ? 1'b1 : tx_register[7];

    // Receive register, MSB first
    always_ff @(posedge clock) begin
        if (count_bit && pin_io)
            rx_register <= {rx_register[6:0], pin_in};
    end

    // Done flags
    always_ff @(posedge clock) begin
        if (reset)
            tx_done <= 1'b0;
        else if (pin_io)
            tx_done <= 1'b0;
        else if (start_communication && ctrl.clear_irq)
            tx_done <= 1'b0;
        else if (bit_count == 4'd8 && shift_edge)
            tx_done <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset)
            rx_done <= 1'b0;
        else if (!pin_io)
            rx_done <= 1'b0;
        else if (start_communication && ctrl.clear_irq)
            rx_done <= 1'b0;
        else if (bit_count == 4'd8 && shift_edge)
            rx_done <= 1'b1;
    end

    // Step function picked by width
    generate
        if (crc_width == 7) begin : g_crc7
            always_comb crc_next = crc7_step(crc, crc_bit);
        end else begin : g_crc16
            always_comb crc_next = crc16_step(crc, crc_bit);
        end
    endgenerate

    always_ff @(posedge clock) begin
        if (reset)
            crc <= '0;
        else if (start_communication && ctrl.clear_crc)
            crc <= '0;
        else if (count_bit)
            crc <= crc_next;
    end

    assign stat.rx_byte = rx_register;
    assign stat.tx_done = tx_done;
    assign stat.rx_done = rx_done;

endmodule

// ==== rtl/mmc_timeout.sv ====
//
// MMC response timeout
// Counts sample edges down from timeout_cycles and raises a
// sticky flag on the next falling edge once the count is spent
//
module mmc_timeout import mmc_pkg::*; #(
    parameter mmc_timer_t timeout_cycles = 32'hFFFF_FFFF
) (
    input  logic clock,
    input  logic reset,
    input  logic start_communication,
    input  logic sample_edge,
    input  logic shift_edge,
    output logic timeout_flag
);

    mmc_timer_t timer_count;
    logic       timer_zero;

    assign timer_zero = (timer_count == '0);

    always_ff @(posedge clock) begin
        if (reset)
            timer_count <= '0;
        else if (start_communication)
            timer_count <= timeout_cycles;
        else if (sample_edge && !timer_zero)
            timer_count <= timer_count - 32'd1;
    end

    // Set at reset so the link starts idle
    always_ff @(posedge clock) begin
        if (reset)
            timeout_flag <= 1'b1;
        else if (start_communication)
            timeout_flag <= 1'b0;
        else if (timer_zero && shift_edge)
            timeout_flag <= 1'b1;
    end

endmodule

// ==== rtl/mmc_interface.sv ====
//
// MMC serial link engine
// Clock divider, CMD lane with CRC-7, DAT lane with CRC-16 and a
// response timeout; mmc_clk runs only while a transaction is open
//
module mmc_interface import mmc_pkg::*; #(
    parameter mmc_timer_t timeout_cycles = 32'hFFFF_FFFF
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           start_communication,
    input  mmc_lane_ctrl_t cmd_ctrl,
    input  mmc_lane_ctrl_t dat_ctrl,
    input  mmc_div_t       mmc_clock_cycle,
    input  logic           mmc_cmd_in,
    input  logic           mmc_dat_in,
    output mmc_lane_stat_t cmd_stat,
    output mmc_lane_stat_t dat_stat,
    output mmc_crc7_t      cmd_crc,
    output mmc_crc16_t     dat_crc,
    output logic           timeout_flag,
    output logic           in_connecting,
    output logic           mmc_clk,
    output logic           mmc_cmd_out,
    output logic           mmc_cmd_io,
    output logic           mmc_dat_out,
    output logic           mmc_dat_io
);

    logic run;
    logic sample_edge;
    logic shift_edge;

    // Any finished lane or an expired timer closes the link
    assign in_connecting = ~(cmd_stat.tx_done | cmd_stat.rx_done |
                             dat_stat.tx_done | dat_stat.rx_done | timeout_flag);
    assign run = in_connecting & ~start_communication;

    mmc_clock_gen u_clock_gen (
        .clock           (clock),
        .reset           (reset),
        .run             (run),
        .mmc_clock_cycle (mmc_clock_cycle),
        .mmc_clk         (mmc_clk),
        .sample_edge     (sample_edge),
        .shift_edge      (shift_edge)
    );

    mmc_lane #(.crc_width(7)) u_cmd_lane (
        .clock               (clock),
        .reset               (reset),
        .start_communication (start_communication),
        .ctrl                (cmd_ctrl),
        .sample_edge         (sample_edge),
        .shift_edge          (shift_edge),
        .pin_in              (mmc_cmd_in),
        .stat                (cmd_stat),
        .crc                 (cmd_crc),
        .pin_out             (mmc_cmd_out),
        .pin_io              (mmc_cmd_io)
    );

    mmc_lane #(.crc_width(16)) u_dat_lane (
        .clock               (clock),
        .reset               (reset),
        .start_communication (start_communication),
        .ctrl                (dat_ctrl),
        .sample_edge         (sample_edge),
        .shift_edge          (shift_edge),
        .pin_in              (mmc_dat_in),
        .stat                (dat_stat),
        .crc                 (dat_crc),
        .pin_out             (mmc_dat_out),
        .pin_io              (mmc_dat_io)
    );

    mmc_timeout #(.timeout_cycles(timeout_cycles)) u_timeout (
        .clock               (clock),
        .reset               (reset),
        .start_communication (start_communication),
        .sample_edge         (sample_edge),
        .shift_edge          (shift_edge),
        .timeout_flag        (timeout_flag)
    );

endmodule

// ==== tb/mmc_interface_chk.sv ====
//
// MMC link engine protocol checks
// Bound to the top level; flags clock gating, pin release
// and done-flag exclusivity violations
//
module mmc_interface_chk import mmc_pkg::*; (
    input logic           clock,
    input logic           reset,
    input logic           in_connecting,
    input logic           mmc_clk,
    input logic           mmc_cmd_out,
    input logic           mmc_cmd_io,
    input mmc_lane_stat_t cmd_stat,
    input mmc_lane_stat_t dat_stat
);

    int fail_count = 0;

    // Card clock is stopped whenever the link is closed
    clk_idle_low: assert property (@(posedge clock) disable iff (reset)
        !in_connecting |-> !mmc_clk)
        else begin
            $error("mmc_clk high while link closed");
            fail_count++;
        end

    cmd_released_high: assert property (@(posedge clock) disable iff (reset)
        mmc_cmd_io |-> mmc_cmd_out)
        else begin
            $error("mmc_cmd_out low while released");
            fail_count++;
        end

    cmd_done_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(cmd_stat.tx_done && cmd_stat.rx_done))
        else begin
            $error("CMD lane tx_done and rx_done both set");
            fail_count++;
        end

    dat_done_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(dat_stat.tx_done && dat_stat.rx_done))
        else begin
            $error("DAT lane tx_done and rx_done both set");
            fail_count++;
        end

endmodule

bind mmc_interface mmc_interface_chk u_chk (
    .clock         (clock),
    .reset         (reset),
    .in_connecting (in_connecting),
    .mmc_clk       (mmc_clk),
    .mmc_cmd_out   (mmc_cmd_out),
    .mmc_cmd_io    (mmc_cmd_io),
    .cmd_stat      (cmd_stat),
    .dat_stat      (dat_stat)
);

// ==== tb/tb_mmc_interface.sv ====
//
// MMC link engine testbench
// Card model on CMD and DAT, bit-level CRC references,
// transmit, receive and timeout transactions with a watchdog
//
module tb_mmc_interface import mmc_pkg::*; ();

    localparam int num_transactions = 13;
    localparam int clock_period = 40;
    localparam int mmc_period = 4 * clock_period;

    logic clock, reset, start_communication, mmc_cmd_in, mmc_dat_in;
    mmc_lane_ctrl_t cmd_ctrl, dat_ctrl;
    mmc_div_t mmc_clock_cycle;
    mmc_lane_stat_t cmd_stat, dat_stat;
    mmc_crc7_t cmd_crc;
    mmc_crc16_t dat_crc;
    logic timeout_flag, in_connecting, mmc_clk;
    logic mmc_cmd_out, mmc_cmd_io, mmc_dat_out, mmc_dat_io;

    logic cmd_bits[$], dat_bits[$], cmd_seen[$], dat_seen[$];
    integer seed = 32'h5cfb7028;
    int error_count = 0;
    int check_count = 0;

    mmc_interface #(.timeout_cycles(40)) i_mmc_interface (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Card side: capture at rise, drive next bit after fall
    always @(posedge mmc_clk) begin
        cmd_seen.push_back(mmc_cmd_out);
        dat_seen.push_back(mmc_dat_out);
    end

    always @(negedge mmc_clk) begin
        #5;
        mmc_cmd_in = (cmd_bits.size() > 0) ? cmd_bits.pop_front() : 1'b1;
        mmc_dat_in = (dat_bits.size() > 0) ? dat_bits.pop_front() : 1'b1;
    end

    function automatic mmc_crc7_t crc7_ref(input mmc_byte_t data);
        mmc_crc7_t c = '0;
        for (int i = 7; i >= 0; i--) begin
            if (c[6] ^ data[i]) c = {c[5:0], 1'b0} ^ 7'h09;
            else c = {c[5:0], 1'b0};
        end
        return c;
    endfunction

    function automatic mmc_crc16_t crc16_ref(input mmc_byte_t data);
        mmc_crc16_t c = '0;
        for (int i = 7; i >= 0; i--) begin
            if (c[15] ^ data[i]) c = {c[14:0], 1'b0} ^ 16'h1021;
            else c = {c[14:0], 1'b0};
        end
        return c;
    endfunction

    function automatic mmc_lane_ctrl_t lane_ctrl(input logic rx, input logic hunt,
                                                 input mmc_byte_t data);
        mmc_lane_ctrl_t c;
        c.receive = rx;
        c.check_start = hunt;
        c.clear_crc = 1'b1;
        c.clear_irq = 1'b1;
        c.load = 1'b1;
        c.tx_byte = data;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic mmc_byte_t first_byte(input logic bits[$]);
        mmc_byte_t b = '0;
        for (int i = 0; i < 8; i++) b = {b[6:0], (i < bits.size()) ? bits[i] : 1'bx};
        return b;
    endfunction

    // Queues hold the card's bits, the first one is presented at once
    task automatic run_transaction(input mmc_lane_ctrl_t c_ctrl, input mmc_lane_ctrl_t d_ctrl);
        cmd_seen.delete();
        dat_seen.delete();
        mmc_cmd_in = (cmd_bits.size() > 0) ? cmd_bits.pop_front() : 1'b1;
        mmc_dat_in = (dat_bits.size() > 0) ? dat_bits.pop_front() : 1'b1;
        cmd_ctrl = c_ctrl;
        dat_ctrl = d_ctrl;
        start_communication = 1'b1;
        @(posedge clock);
        #5;
        start_communication = 1'b0;
        while (!in_connecting) begin
            @(posedge clock);
            #5;
        end
        while (in_connecting) begin
            @(posedge clock);
            #5;
        end
        // Card model acts on the closing fall before the next setup
        @(posedge clock);
        #5;
    endtask

    initial begin
        #(12 * num_transactions * 20 * mmc_period);
        $display("Watchdog expired: a transaction never finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        mmc_byte_t data;
        reset = 1'b1;
        start_communication = 1'b0;
        cmd_ctrl = '0;
        dat_ctrl = '0;
        mmc_clock_cycle = 8'd4;
        mmc_cmd_in = 1'b1;
        mmc_dat_in = 1'b1;
        repeat (5) @(posedge clock);
        #5;
        reset = 1'b0;

        check_value("reset in_connecting", 0, in_connecting);
        check_value("reset timeout_flag", 1, timeout_flag);
        check_value("reset io", 2'b11, {mmc_cmd_io, mmc_dat_io});
        check_value("reset mmc_clk", 0, mmc_clk);

        // Idle lane listens for a start bit that never comes
        for (int n = 0; n < 4; n++) begin
            data = $random(seed);
            run_transaction(lane_ctrl(0, 0, data), lane_ctrl(1, 1, 8'h00));
            check_value("cmd tx bits", data, first_byte(cmd_seen));
            check_value("cmd tx_done", 1, cmd_stat.tx_done);
            check_value("cmd tx crc", crc7_ref(data), cmd_crc);
        end
        for (int n = 0; n < 4; n++) begin
            data = $random(seed);
            run_transaction(lane_ctrl(1, 1, 8'h00), lane_ctrl(0, 0, data));
            check_value("dat tx bits", data, first_byte(dat_seen));
            check_value("dat tx_done", 1, dat_stat.tx_done);
            check_value("dat tx crc", crc16_ref(data), dat_crc);
        end
        for (int n = 0; n < 2; n++) begin
            data = $random(seed) & 8'h7f;
            cmd_bits = {1'b1, 1'b1, 1'b1};
            for (int i = 7; i >= 0; i--) cmd_bits.push_back(data[i]);
            run_transaction(lane_ctrl(1, 1, 8'h00), lane_ctrl(1, 1, 8'h00));
            check_value("cmd rx byte", data, cmd_stat.rx_byte);
            check_value("cmd rx_done", 1, cmd_stat.rx_done);
            check_value("cmd rx crc", crc7_ref(data), cmd_crc);
        end
        for (int n = 0; n < 2; n++) begin
            data = $random(seed);
            for (int i = 7; i >= 0; i--) dat_bits.push_back(data[i]);
            run_transaction(lane_ctrl(1, 1, 8'h00), lane_ctrl(1, 0, 8'h00));
            check_value("dat rx byte", data, dat_stat.rx_byte);
            check_value("dat rx_done", 1, dat_stat.rx_done);
            check_value("dat rx crc", crc16_ref(data), dat_crc);
        end

        // Card stays silent on both pins
        run_transaction(lane_ctrl(1, 1, 8'h00), lane_ctrl(1, 1, 8'h00));
        check_value("timeout done flags", 0,
                    {cmd_stat.tx_done, cmd_stat.rx_done, dat_stat.tx_done, dat_stat.rx_done});
        check_value("timeout flag", 1, timeout_flag);
        repeat (20) begin
            @(posedge clock);
            #5;
            check_value("timeout in_connecting", 0, in_connecting);
            check_value("timeout mmc_clk", 0, mmc_clk);
        end

        error_count += i_mmc_interface.u_chk.fail_count;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/mmc_pkg.sv
rtl/mmc_clock_gen.sv
rtl/mmc_lane.sv
rtl/mmc_timeout.sv
rtl/mmc_interface.sv
tb/mmc_interface_chk.sv
tb/tb_mmc_interface.sv

// ==== Makefile ====
# Verilator lint and simulation for the MMC link engine

VERILATOR ?= verilator
TOP       ?= tb_mmc_interface
RTL_TOP   ?= mmc_interface
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
